// File: rtl/cpu_pkg.sv
// **************************************************
// CPU package: word and opcode types, instruction
// field layout and byte bus constants
// **************************************************
package cpu_pkg;

  typedef logic [31:0] word_t;      // Data, address and instruction word

  typedef enum logic [3:0] {
    NOP   = 4'h0,
    LDI   = 4'h1,                   // acc = operand
    LOAD  = 4'h2,                   // acc = mem[operand]
    STORE = 4'h3,                   // mem[operand] = acc
    ADD   = 4'h4,                   // acc = acc + mem[operand]
    SUB   = 4'h5,                   // acc = acc - mem[operand]
    JMP   = 4'h6,                   // pc = operand
    JZ    = 4'h7,                   // pc = operand if acc == 0
    HALT  = 4'hF
  } opcode_t;

  // Instruction layout
  localparam int OPCODE_MSB   = 31;
  localparam int OPCODE_LSB   = 28;
  localparam int OPERAND_BITS = 28; // Immediate value or word address

  // Byte bus
  localparam int BYTES_PER_WORD = 4;  // Beats per direction
  localparam int WRITE_FLAG_BIT = 31; // Address bit that marks a store

  typedef logic [3:0] beat_t;       // Bridge beat counter, 0 is idle

  // Last output beat and last input beat of a transaction
  localparam beat_t OUT_LAST_BEAT = beat_t'(BYTES_PER_WORD);
  localparam beat_t IN_LAST_BEAT  = beat_t'(2 * BYTES_PER_WORD);

endpackage

// File: rtl/mem_bus_if.sv
// **************************************************
// Word memory bus between CPU core and byte bridge
// **************************************************
`timescale 1ns/1ps

interface mem_bus_if;

  logic           req;    // One-cycle request pulse
  logic           write;  // Store when set
  cpu_pkg::word_t addr;   // Word address
  cpu_pkg::word_t wdata;
  cpu_pkg::word_t rdata;  // Valid while done is high
  logic           done;   // One-cycle completion pulse

  modport core (
    output req, write, addr, wdata,
    input  rdata, done
  );

  modport bridge (
    input  req, write, addr, wdata,
    output rdata, done
  );

endinterface

// File: rtl/cpu_core.sv
// **************************************************
// Accumulator CPU core, fetches and executes one
// instruction at a time over the word memory bus
// **************************************************
`timescale 1ns/1ps

module cpu_core (
  input  logic      clk,
  input  logic      rst_n,
  mem_bus_if.core   bus
);

  typedef enum logic [2:0] {
    FETCH,
    WAIT_FETCH,
    EXECUTE,
    MEM_ACCESS,
    WAIT_MEM,
    HALTED
  } state_t;

  state_t           state;
  cpu_pkg::word_t   pc;
  cpu_pkg::word_t   acc;
  cpu_pkg::word_t   ir;
  cpu_pkg::word_t   operand;
  cpu_pkg::word_t   alu_result;
  cpu_pkg::opcode_t op;
  logic             is_mem_op;
  logic             acc_zero;

  // Decode
  assign op       = cpu_pkg::opcode_t'(ir[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);
  assign operand  = cpu_pkg::word_t'(ir[cpu_pkg::OPERAND_BITS-1:0]); // Zero extended
  assign acc_zero = (acc == '0);

  always_comb begin
    is_mem_op = (op == cpu_pkg::LOAD)  || (op == cpu_pkg::STORE) ||
                (op == cpu_pkg::ADD)   || (op == cpu_pkg::SUB);
  end

  // Accumulator result, rdata only matters in WAIT_MEM
  always_comb begin
    case (op)
      cpu_pkg::LDI:  alu_result = operand;
      cpu_pkg::LOAD: alu_result = bus.rdata;
      cpu_pkg::ADD:  alu_result = acc + bus.rdata;
      cpu_pkg::SUB:  alu_result = acc - bus.rdata;
      default:       alu_result = acc;          // STORE and the rest keep acc
    endcase
  end

  // Instruction register
  always_ff @(posedge clk) begin
    if (state == WAIT_FETCH && bus.done) begin
      ir <= bus.rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= FETCH;
      pc        <= '0;
      acc       <= '0;
      bus.req   <= 1'b0;
      bus.write <= 1'b0;
      bus.addr  <= '0;
      bus.wdata <= '0;
    end else begin
      bus.req <= 1'b0;                          // Pulse only
      case (state)
        FETCH: begin
          bus.req   <= 1'b1;
          bus.write <= 1'b0;
          bus.addr  <= pc;
          state     <= WAIT_FETCH;
        end

        WAIT_FETCH: begin
          if (bus.done) begin
            pc    <= pc + 32'd1;
            state <= EXECUTE;
          end
        end

        EXECUTE: begin
          case (op)
            cpu_pkg::LDI: begin
              acc   <= alu_result;
              state <= FETCH;
            end
            cpu_pkg::JMP: begin
              pc    <= operand;
              state <= FETCH;
            end
            cpu_pkg::JZ: begin
              if (acc_zero) begin
                pc <= operand;
              end
              state <= FETCH;
            end
            cpu_pkg::HALT: begin
              state <= HALTED;
            end
            default: begin
              // Memory ops need a second transaction, others act as NOP
              state <= is_mem_op ? MEM_ACCESS : FETCH;
            end
          endcase
        end

        MEM_ACCESS: begin
          bus.req   <= 1'b1;
          bus.write <= (op == cpu_pkg::STORE);
          bus.addr  <= operand;
          bus.wdata <= acc;
          state     <= WAIT_MEM;
        end

        WAIT_MEM: begin
          if (bus.done) begin
            acc   <= alu_result;                // Unchanged for STORE
            state <= FETCH;
          end
        end

        HALTED: begin
          state <= HALTED;                      // No more requests
        end

        default: begin
          state <= FETCH;
        end
      endcase
    end
  end

endmodule

// File: rtl/byte_bus_bridge.sv
// **************************************************
// Byte bus bridge, serializes one word transaction
// onto the shared 8-bit pins and gathers the reply
// **************************************************
`timescale 1ns/1ps

module byte_bus_bridge (
  input  logic       clk,
  input  logic       rst_n,
  mem_bus_if.bridge  bus,
  input  logic [7:0] uio_in,
  output logic [7:0] uo_out,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);

  cpu_pkg::beat_t beat_cnt;     // 0 idle, 1-4 output beats, 5-8 input beats
  cpu_pkg::word_t merged_addr;
  cpu_pkg::word_t addr_q;
  cpu_pkg::word_t wdata_q;
  cpu_pkg::word_t read_q;
  logic [1:0]     byte_sel;
  logic           start;
  logic           in_beat;
  logic           done_q;

  // Write flag rides in the top address bit
  always_comb begin
    merged_addr                          = bus.addr;
    merged_addr[cpu_pkg::WRITE_FLAG_BIT] = bus.write;
  end

  assign start    = (beat_cnt == '0) && bus.req;
  assign in_beat  = (beat_cnt > cpu_pkg::OUT_LAST_BEAT);
  assign byte_sel = beat_cnt[1:0];      // Beats 1 to 3 load bytes 1 to 3

  // Pin sequencer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
      uo_out   <= '0;
      uio_out  <= '0;
      uio_oe   <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (beat_cnt == '0) begin
        if (bus.req) begin
          beat_cnt <= 4'd1;
          uo_out   <= merged_addr[7:0];     // Byte 0 straight from the bus
          uio_out  <= bus.wdata[7:0];
          uio_oe   <= 8'hFF;
        end
      end else if (beat_cnt < cpu_pkg::OUT_LAST_BEAT) begin
        beat_cnt <= beat_cnt + 4'd1;
        uo_out   <= addr_q[8*byte_sel +: 8];
        uio_out  <= wdata_q[8*byte_sel +: 8];
      end else if (beat_cnt == cpu_pkg::OUT_LAST_BEAT) begin
        // Release the pins for the read beats
        beat_cnt <= beat_cnt + 4'd1;
        uo_out   <= '0;
        uio_out  <= '0;
        uio_oe   <= '0;
      end else if (beat_cnt < cpu_pkg::IN_LAST_BEAT) begin
        beat_cnt <= beat_cnt + 4'd1;
      end else begin
        beat_cnt <= '0;
        done_q   <= 1'b1;                   // Last read byte lands now
      end
    end
  end

  // Latched request and read shift, LSB first
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q  <= merged_addr;
      wdata_q <= bus.wdata;
    end
    if (in_beat) begin
      read_q <= {uio_in, read_q[31:8]};
    end
  end

  assign bus.rdata = read_q;
  assign bus.done  = done_q;

endmodule

// File: rtl/tt_um_cpu_handler.sv
// **************************************************
// Tile top level, CPU core behind the byte bus bridge
// **************************************************
`timescale 1ns/1ps

module tt_um_cpu_handler (
  input  logic [7:0] ui_in,     // Not used
  input  logic [7:0] uio_in,    // Read bytes
  output logic [7:0] uo_out,    // Address bytes
  output logic [7:0] uio_out,   // Write-data bytes
  output logic [7:0] uio_oe,    // All ones during output beats
  input  logic       ena,
  input  logic       clk,
  input  logic       rst_n
);

  logic unused;

  mem_bus_if bus ();

  cpu_core u_core (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus.core)
  );

  byte_bus_bridge u_bridge (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus.bridge),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  assign unused = &{ui_in, ena, 1'b0};  // Inputs without a function

endmodule

// File: test/bus_checker.sv
// **************************************************
// Pin timing assertions for the byte bus bridge
// **************************************************
`timescale 1ns/1ps

module bus_checker (
  input logic           clk,
  input logic           rst_n,
  input cpu_pkg::beat_t beat_cnt,
  input logic           start,      // req seen while idle
  input logic           done,
  input logic [7:0]     uo_out,
  input logic [7:0]     uio_out,
  input logic [7:0]     uio_oe
);

  // Drive enable is all or nothing
  a_oe_levels: assert property (@(posedge clk) disable iff (!rst_n)
      (uio_oe == 8'h00) || (uio_oe == 8'hFF))
    else $error("uio_oe is neither 00 nor FF: %h", uio_oe);

  a_done_latency: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> ##9 done)
    else $error("done missing 9 cycles after a request");

  a_done_origin: assert property (@(posedge clk) disable iff (!rst_n)
      done |-> $past(start, 9))
    else $error("done without a request 9 cycles earlier");

  // Pins rest at zero between transactions
  a_idle_pins: assert property (@(posedge clk) disable iff (!rst_n)
      (beat_cnt == '0) |-> (uo_out == '0 && uio_out == '0 && uio_oe == '0))
    else $error("pins not zero while the bridge is idle");

endmodule

bind byte_bus_bridge bus_checker u_bus_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .beat_cnt (beat_cnt),
  .start    (start),
  .done     (done_q),
  .uo_out   (uo_out),
  .uio_out  (uio_out),
  .uio_oe   (uio_oe)
);

// File: test/tb_cpu_handler.sv
// **************************************************
// Testbench for the CPU tile with a pin-level memory
// model and a reference model of the programs
// **************************************************
`timescale 1ns/1ps

module tb_cpu_handler;

  localparam int MAX_CYCLES = 3000;   // Three programs of at most 25 transactions each
  localparam int MAX_XACTS  = 25;
  localparam int HALT_WAIT  = 100;    // Quiet cycles expected after HALT

  typedef struct packed {
    cpu_pkg::word_t addr;
    logic           write;
    cpu_pkg::word_t data;
  } xact_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uio_in;
  logic [7:0] uo_out;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  cpu_pkg::word_t image [0:255];      // Program and data loaded at reset
  cpu_pkg::word_t mem [0:255];        // External memory seen by the DUT
  cpu_pkg::word_t ref_mem [0:255];
  cpu_pkg::word_t ref_pc;
  cpu_pkg::word_t ref_acc;
  logic           ref_halted;
  xact_t          exp_list [0:31];
  int             exp_count = 0;
  string          test_name = "reset";

  cpu_pkg::word_t m_addr;             // Memory model side
  cpu_pkg::word_t m_data;
  cpu_pkg::word_t rd_word;
  int             m_beats;
  int             in_left;

  cpu_pkg::word_t c_addr;             // Compare side
  cpu_pkg::word_t c_data;
  int             c_beats = 0;
  int             cmp_idx = 0;
  logic           first_after_reset = 1'b0;
  int             err_value = 0;
  int             err_other = 0;
  int             cycle_count = 0;

  tt_um_cpu_handler dut (
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .ena     (ena),
    .clk     (clk),
    .rst_n   (rst_n)
  );

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Run timed out after %0d cycles before the programs finished", cycle_count);
      $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic cpu_pkg::word_t enc(input cpu_pkg::opcode_t op, input int operand);
    return {op, operand[27:0]};
  endfunction

  function automatic void add_expected(input cpu_pkg::word_t a, input logic w,
                                       input cpu_pkg::word_t d);
    exp_list[exp_count[4:0]] = '{addr: a, write: w, data: d};
    exp_count = exp_count + 1;
  endfunction

  // One instruction of the reference machine with its bus transactions
  function automatic void step_model();
    cpu_pkg::word_t   instr;
    cpu_pkg::word_t   opnd;
    cpu_pkg::opcode_t op;
    instr = ref_mem[ref_pc[7:0]];
    add_expected(ref_pc, 1'b0, '0);   // Fetch
    op      = cpu_pkg::opcode_t'(instr[cpu_pkg::OPCODE_MSB:cpu_pkg::OPCODE_LSB]);
    opnd    = {4'h0, instr[cpu_pkg::OPERAND_BITS-1:0]};
    ref_pc  = ref_pc + 32'd1;
    case (op)
      cpu_pkg::LDI:   ref_acc = opnd;
      cpu_pkg::LOAD: begin
        add_expected(opnd, 1'b0, '0);
        ref_acc = ref_mem[opnd[7:0]];
      end
      cpu_pkg::STORE: begin
        add_expected(opnd, 1'b1, ref_acc);
        ref_mem[opnd[7:0]] = ref_acc;
      end
      cpu_pkg::ADD: begin
        add_expected(opnd, 1'b0, '0);
        ref_acc = ref_acc + ref_mem[opnd[7:0]];
      end
      cpu_pkg::SUB: begin
        add_expected(opnd, 1'b0, '0);
        ref_acc = ref_acc - ref_mem[opnd[7:0]];
      end
      cpu_pkg::JMP:   ref_pc = opnd;
      cpu_pkg::JZ: begin
        if (ref_acc == '0) begin
          ref_pc = opnd;
        end
      end
      cpu_pkg::HALT:  ref_halted = 1'b1;
      default:        ;               // NOP
    endcase
  endfunction

  task automatic build_expected();
    ref_mem    = image;
    ref_pc     = '0;
    ref_acc    = '0;
    ref_halted = 1'b0;
    exp_count  = 0;
    while (!ref_halted && exp_count < MAX_XACTS) begin
      step_model();
    end
  endtask

  task automatic load_program(input int which);
    for (int i = 0; i < 256; i++) begin
      image[i[7:0]] = $urandom();     // Random data words
    end
    case (which)
      1: begin                        // Arithmetic
        image[8'd0] = enc(cpu_pkg::LDI, 5);
        image[8'd1] = enc(cpu_pkg::ADD, 32);
        image[8'd2] = enc(cpu_pkg::SUB, 33);
        image[8'd3] = enc(cpu_pkg::STORE, 40);
        image[8'd4] = enc(cpu_pkg::LOAD, 34);
        image[8'd5] = enc(cpu_pkg::ADD, 35);
        image[8'd6] = enc(cpu_pkg::STORE, 41);
        image[8'd7] = enc(cpu_pkg::HALT, 0);
      end
      2: begin                        // JZ taken, JZ not taken, JMP
        image[8'd0]  = enc(cpu_pkg::LDI, 0);
        image[8'd1]  = enc(cpu_pkg::JZ, 4);
        image[8'd2]  = enc(cpu_pkg::LDI, 9);
        image[8'd3]  = enc(cpu_pkg::HALT, 0);
        image[8'd4]  = enc(cpu_pkg::LDI, 7);
        image[8'd5]  = enc(cpu_pkg::JZ, 2);
        image[8'd6]  = enc(cpu_pkg::JMP, 9);
        image[8'd7]  = enc(cpu_pkg::NOP, 0);
        image[8'd8]  = enc(cpu_pkg::HALT, 0);
        image[8'd9]  = enc(cpu_pkg::ADD, 36);
        image[8'd10] = enc(cpu_pkg::STORE, 40);
        image[8'd11] = enc(cpu_pkg::HALT, 0);
      end
      default: begin                  // Store then load back and store again
        image[8'd0] = enc(cpu_pkg::LOAD, 32);
        image[8'd1] = enc(cpu_pkg::ADD, 33);
        image[8'd2] = enc(cpu_pkg::STORE, 48);
        image[8'd3] = enc(cpu_pkg::LDI, 1);
        image[8'd4] = enc(cpu_pkg::LOAD, 48);
        image[8'd5] = enc(cpu_pkg::STORE, 49);
        image[8'd6] = enc(cpu_pkg::HALT, 0);
      end
    endcase
  endtask

  // Memory model that answers each transaction from the pins
  initial begin
    uio_in  = '0;
    m_beats = 0;
    in_left = 0;
    forever begin
      @(posedge clk);
      #2;
      if (in_left > 0) begin
        uio_in  = rd_word[7:0];       // Read bytes LSB first
        rd_word = rd_word >> 8;
        in_left = in_left - 1;
      end else begin
        uio_in = '0;
      end
      @(negedge clk);
      if (!rst_n) begin
        mem     = image;
        m_beats = 0;
        in_left = 0;
      end else if (uio_oe == 8'hFF) begin
        m_addr  = {uo_out, m_addr[31:8]};
        m_data  = {uio_out, m_data[31:8]};
        m_beats = m_beats + 1;
        if (m_beats == cpu_pkg::BYTES_PER_WORD) begin
          rd_word = mem[m_addr[7:0]];   // Old word is returned for a store too
          if (m_addr[cpu_pkg::WRITE_FLAG_BIT]) begin
            mem[m_addr[7:0]] = m_data;
          end
          in_left = cpu_pkg::BYTES_PER_WORD;
          m_beats = 0;
        end
      end
    end
  end

  task automatic check_word(input string what, input cpu_pkg::word_t expected,
                            input cpu_pkg::word_t actual);
    if (actual !== expected) begin
      err_value = err_value + 1;
      $display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      err_value = err_value + 1;
      $display("error %s %s: expected %b actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    err_other = err_other + 1;
    $display("%s: %s", test_name, msg);
  endtask

  task automatic compare_xact();
    xact_t e;
    string tag;
    if (cmp_idx < exp_count) begin
      e   = exp_list[cmp_idx[4:0]];
      tag = $sformatf("transaction %0d", cmp_idx);
      check_word({tag, " address"}, {1'b0, e.addr[30:0]}, {1'b0, c_addr[30:0]});
      check_flag({tag, " write flag"}, e.write, c_addr[cpu_pkg::WRITE_FLAG_BIT]);
      if (e.write) begin
        check_word({tag, " store data"}, e.data, c_data);
      end
      cmp_idx = cmp_idx + 1;
    end
  endtask

  // Rebuilds transactions from the pins and compares them in order
  always @(negedge clk) begin
    if (!rst_n) begin
      check_word("pins in reset", '0, {8'h00, uo_out, uio_out, uio_oe});
      c_beats           = 0;
      cmp_idx           = 0;
      first_after_reset = 1'b1;
    end else begin
      if (first_after_reset) begin
        check_word("pins after reset", '0, {8'h00, uo_out, uio_out, uio_oe});
        first_after_reset = 1'b0;
      end
      if (uio_oe == 8'hFF) begin
        if (c_beats == 0 && cmp_idx >= exp_count) begin
          report_failure("a bus transaction started after the program reached HALT");
        end
        c_addr  = {uo_out, c_addr[31:8]};
        c_data  = {uio_out, c_data[31:8]};
        c_beats = c_beats + 1;
        if (c_beats == cpu_pkg::BYTES_PER_WORD) begin
          compare_xact();
          c_beats = 0;
        end
      end else begin
        if (c_beats != 0) begin
          report_failure($sformatf("uio_oe dropped after %0d of 4 output beats", c_beats));
          c_beats = 0;
        end
        // Input beats and idle cycles leave every pin at zero
        check_word("pins outside output beats", '0, {8'h00, uo_out, uio_out, uio_oe});
      end
    end
  end

  task automatic run_program(input int which, input string name);
    @(posedge clk);
    #2;
    rst_n     = 1'b0;
    test_name = name;
    load_program(which);
    build_expected();
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    while (cmp_idx < exp_count) begin
      @(posedge clk);
    end
    repeat (HALT_WAIT) @(posedge clk);  // Bus must stay quiet after HALT
  endtask

  initial begin
    rst_n = 1'b0;
    ena   = 1'b1;
    ui_in = '0;
    void'($urandom(65));
    run_program(1, "arith");
    run_program(2, "branch");
    run_program(3, "store_load");
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/cpu_core.sv
rtl/byte_bus_bridge.sv
rtl/tt_um_cpu_handler.sv
test/bus_checker.sv
test/tb_cpu_handler.sv

// File: run.sh
#!/bin/sh
# Compile the CPU tile testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_cpu_handler -f files.f -o sim_cpu_handler || exit 1
out=$(./obj_dir/sim_cpu_handler)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1
